// File: list.f
rtl/noise_pkg.sv
rtl/noise_estimation_fsm.sv
rtl/block_mean_unit.sv
rtl/block_energy_unit.sv
rtl/noise_combiner.sv
rtl/noise_estimator_top.sv
tests/noise_estimator_assert.sv
tests/noise_estimator_tb.sv

// File: run.sh
#!/bin/sh
# build and run the noise estimator testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module noise_estimator_tb -f list.f -o sim_noise

./obj_dir/sim_noise 2>&1 | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
	exit 0
else
	exit 1
fi

// File: tests/noise_estimator_tb.sv
//**************************************************
// testbench of the noise estimator
// clock and reset, random frames with gaps, block
// and frame reference model, compare process and
// the final verdict
//**************************************************

module noise_estimator_tb
	import noise_pkg::*;
();

	localparam int LOG2_SAMPLES = 6;
	localparam int BLOCK_LEN    = 1 << LOG2_SAMPLES;
	localparam int MAX_BLOCKS   = 1 << MAX_LOG2_BLOCKS;
	localparam int CLK_PERIOD   = 40;
	localparam int MAX_WAIT     = 4000;  // cycles allowed per wait loop

	logic          clk;
	logic          rst_n;
	logic          start_of_frame;
	logic [2:0]    log2_blocks;
	sample_t       sample;
	logic          sample_valid;
	logic          sampling;
	logic          block_valid;
	block_stats_t  block_stats;
	logic          noise_valid;
	noise_result_t noise;

	sample_t      blk [BLOCK_LEN];  // accepted samples of the open block
	int           blk_cnt = 0;
	time          last_accept = 0;
	block_stats_t exp_blocks [$];
	block_stats_t frame_stats [MAX_BLOCKS];
	int           frame_blocks = 0;
	int           noise_count = 0;

	noise_estimator_top #(
		.LOG2_SAMPLES(LOG2_SAMPLES)
	) u_noise_estimator_top (
		.clk            (clk),
		.rst_n          (rst_n),
		.start_of_frame (start_of_frame),
		.log2_blocks    (log2_blocks),
		.sample         (sample),
		.sample_valid   (sample_valid),
		.sampling       (sampling),
		.block_valid    (block_valid),
		.block_stats    (block_stats),
		.noise_valid    (noise_valid),
		.noise          (noise)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// block mean and variance from the raw samples
	function automatic block_stats_t ref_block(input sample_t s [BLOCK_LEN]);
		int unsigned  sum;
		int unsigned  sq_sum;
		int unsigned  mean;
		int unsigned  sq_mean;
		block_stats_t r;
		sum    = 0;
		sq_sum = 0;
		for (int i = 0; i < BLOCK_LEN; i++) begin
			sum    += 32'(s[i]);
			sq_sum += 32'(s[i]) * 32'(s[i]);
		end
		mean       = sum >> LOG2_SAMPLES;
		sq_mean    = sq_sum >> LOG2_SAMPLES;  // truncated mean of squares
		r.mean     = stat_t'(mean);
		r.variance = stat_t'(sq_mean - mean * mean);
		return r;
	endfunction

	function automatic noise_result_t ref_noise(input block_stats_t b [MAX_BLOCKS],
		input int n, input int l2b);
		int unsigned   mean_sum;
		int unsigned   var_sum;
		noise_result_t r;
		mean_sum = 0;
		var_sum  = 0;
		for (int i = 0; i < n; i++) begin
			mean_sum += 32'(b[i].mean);
			var_sum  += 32'(b[i].variance);
		end
		r.noise_mean     = stat_t'(mean_sum >> l2b);
		r.noise_variance = stat_t'(var_sum >> l2b);
		return r;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			abort_run($sformatf("FAIL at %0t: %s expected %b, got %b", $time, name, exp, act));
		end
	endtask

	task automatic check_block(input block_stats_t exp, input block_stats_t act);
		if (act !== exp) begin
			abort_run($sformatf("FAIL at %0t: block_stats expected mean/var %0d/%0d, got %0d/%0d",
				$time, exp.mean, exp.variance, act.mean, act.variance));
		end
	endtask

	task automatic check_noise(input noise_result_t exp, input noise_result_t act);
		if (act !== exp) begin
			abort_run($sformatf("FAIL at %0t: noise expected mean/var %0d/%0d, got %0d/%0d",
				$time, exp.noise_mean, exp.noise_variance, act.noise_mean, act.noise_variance));
		end
	endtask

	// monitor of accepted samples
	always @(posedge clk) begin
		if (rst_n && sampling && sample_valid) begin
			blk[blk_cnt] = sample;
			last_accept  = $time;
			if (blk_cnt == BLOCK_LEN - 1) begin
				exp_blocks.push_back(ref_block(blk));
				blk_cnt = 0;
			end else begin
				blk_cnt = blk_cnt + 1;
			end
		end
	end

	// compare process
	always @(posedge clk) begin
		block_stats_t exp_blk;
		if (!rst_n) begin
			frame_blocks = 0;
		end else if (block_valid) begin
			if (exp_blocks.size() == 0) begin
				abort_run("block_valid came without a completed block of samples");
			end else begin
				exp_blk = exp_blocks.pop_front();
				check_block(exp_blk, block_stats);
				frame_stats[frame_blocks] = exp_blk;
				frame_blocks++;
			end
		end else if (noise_valid) begin
			if (frame_blocks != (1 << log2_blocks)) begin
				abort_run("noise_valid came after the wrong number of blocks");
			end else if ($time - last_accept != 3 * CLK_PERIOD) begin
				abort_run($sformatf("FAIL at %0t: noise_valid latency expected 3, got %0d",
					$time, ($time - last_accept) / CLK_PERIOD));
			end else begin
				check_noise(ref_noise(frame_stats, frame_blocks, int'(log2_blocks)), noise);
				frame_blocks = 0;
				noise_count++;
			end
		end
	end

	task automatic drive_sample(input bit fixed, input sample_t level);
		sample       <= fixed ? level : sample_t'($urandom_range(0, 255));
		sample_valid <= ($urandom_range(0, 3) != 0);  // about one gap in four
	endtask

	task automatic run_frame(input logic [2:0] l2b, input bit fixed, input sample_t level);
		int n;
		@(posedge clk);
		log2_blocks    <= l2b;
		start_of_frame <= 1'b1;
		@(posedge clk);
		start_of_frame <= 1'b0;
		n = 0;
		while (!sampling && n < MAX_WAIT) begin
			drive_sample(fixed, level);
			@(posedge clk);
			n++;
		end
		if (!sampling) begin
			abort_run("sampling never rose after start_of_frame");
		end else begin
			n = 0;
			while (!noise_valid && n < MAX_WAIT) begin
				drive_sample(fixed, level);
				start_of_frame <= (n == 20);  // lands inside the running frame
				@(posedge clk);
				n++;
			end
			if (!noise_valid) begin
				abort_run("noise_valid never came for the running frame");
			end else begin
				check_level("sampling", 1'b0, sampling);
				start_of_frame <= 1'b0;
				sample_valid   <= 1'b0;
			end
		end
	endtask

	initial begin
		void'($urandom(32'h1a164a5d));
		rst_n          = 1'b0;
		start_of_frame = 1'b0;
		log2_blocks    = 3'd0;
		sample         = '0;
		sample_valid   = 1'b0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		// offered samples are dropped while idle
		for (int i = 0; i < 8; i++) begin
			drive_sample(1'b0, '0);
			@(posedge clk);
			check_level("sampling", 1'b0, sampling);
			check_level("block_valid", 1'b0, block_valid);
			check_level("noise_valid", 1'b0, noise_valid);
		end
		run_frame(3'd0, 1'b1, 8'd200);
		run_frame(3'd1, 1'b0, '0);
		run_frame(3'd3, 1'b0, '0);
		run_frame(3'd1, 1'b1, 8'd37);
		run_frame(3'd0, 1'b0, '0);
		repeat (4) @(posedge clk);
		if (noise_count != 5 || exp_blocks.size() != 0) begin
			abort_run("frame results missing or blocks left without block_valid");
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

// File: tests/noise_estimator_assert.sv
//**************************************************
// concurrent checks on the noise estimator top
// ready pairing, block_valid timing and the stop
// of sampling after a block ends
//**************************************************

module noise_estimator_assert
	import noise_pkg::*;
(
	input logic         clk,
	input logic         rst_n,
	input logic         sampling,
	input sample_beat_t beat,
	input logic         beat_en,
	input logic         mean_ready,
	input logic         energy_ready,
	input logic         block_valid
);

	// both units close a block in the same cycle
	ready_pair: assert property (@(posedge clk) disable iff (!rst_n)
		mean_ready == energy_ready)
		else $error("mean_ready and energy_ready differ");

	block_after_mean: assert property (@(posedge clk) disable iff (!rst_n)
		mean_ready |=> block_valid)
		else $error("block_valid missing one cycle after mean_ready");

	block_only_after_mean: assert property (@(posedge clk) disable iff (!rst_n)
		block_valid |-> $past(mean_ready))
		else $error("block_valid without mean_ready one cycle before");

	stop_after_block: assert property (@(posedge clk) disable iff (!rst_n)
		(beat_en && beat.block_last) |=> !sampling)
		else $error("sampling still high after the last sample of a block");

endmodule

bind noise_estimator_top noise_estimator_assert u_noise_estimator_assert (
	.clk          (clk),
	.rst_n        (rst_n),
	.sampling     (sampling),
	.beat         (beat),
	.beat_en      (beat_en),
	.mean_ready   (mean_ready),
	.energy_ready (energy_ready),
	.block_valid  (block_valid)
);

// File: rtl/noise_estimator_top.sv
//************************************************
// noise estimator top level
// frame controller, block mean and energy units
// and the combiner
//************************************************

module noise_estimator_top
	import noise_pkg::*;
#(
	parameter int LOG2_SAMPLES = 6
) (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          start_of_frame,
	input  logic [2:0]    log2_blocks,
	input  sample_t       sample,
	input  logic          sample_valid,
	output logic          sampling,
	output logic          block_valid,
	output block_stats_t  block_stats,
	output logic          noise_valid,
	output noise_result_t noise
);

	sample_beat_t beat;
	logic         beat_en;
	logic         mean_ready;
	mean_result_t mean_res;
	logic         energy_ready;
	stat_t        energy;

	noise_estimation_fsm #(
		.LOG2_SAMPLES(LOG2_SAMPLES)
	) u_noise_estimation_fsm (
		.clk            (clk),
		.rst_n          (rst_n),
		.start_of_frame (start_of_frame),
		.log2_blocks    (log2_blocks),
		.sample         (sample),
		.sample_valid   (sample_valid),
		.block_valid    (block_valid),  // end of block back to the controller
		.sampling       (sampling),
		.beat           (beat),
		.beat_en        (beat_en)
	);

	block_mean_unit #(
		.LOG2_SAMPLES(LOG2_SAMPLES)
	) u_block_mean_unit (
		.clk        (clk),
		.rst_n      (rst_n),
		.beat       (beat),
		.beat_en    (beat_en),
		.mean_ready (mean_ready),
		.mean_res   (mean_res)
	);

	block_energy_unit #(
		.LOG2_SAMPLES(LOG2_SAMPLES)
	) u_block_energy_unit (
		.clk          (clk),
		.rst_n        (rst_n),
		.beat         (beat),
		.beat_en      (beat_en),
		.energy_ready (energy_ready),
		.energy       (energy)
	);

	noise_combiner u_noise_combiner (
		.clk          (clk),
		.rst_n        (rst_n),
		.log2_blocks  (log2_blocks),
		.mean_ready   (mean_ready),
		.mean_res     (mean_res),
		.energy_ready (energy_ready),
		.energy       (energy),
		.block_valid  (block_valid),
		.block_stats  (block_stats),
		.noise_valid  (noise_valid),
		.noise        (noise)
	);

endmodule

// File: rtl/noise_combiner.sv
//************************************************
// noise combiner
// block variance from mean and mean of squares,
// frame sums of block statistics and the frame
// noise mean and variance
//************************************************

module noise_combiner
	import noise_pkg::*;
(
	input  logic          clk,
	input  logic          rst_n,
	input  logic [2:0]    log2_blocks,
	input  logic          mean_ready,
	input  mean_result_t  mean_res,
	input  logic          energy_ready,
	input  stat_t         energy,
	output logic          block_valid,
	output block_stats_t  block_stats,
	output logic          noise_valid,
	output noise_result_t noise
);

	localparam int FSUM_WIDTH = SQ_WIDTH + MAX_LOG2_BLOCKS;

	logic                  stats_en;
	stat_t                 mean_sq;
	stat_t                 variance;
	logic                  frame_last_q;
	logic [FSUM_WIDTH-1:0] mean_sum;
	logic [FSUM_WIDTH-1:0] var_sum;

	assign stats_en = mean_ready && energy_ready;
	assign mean_sq  = mean_res.mean * mean_res.mean;
	assign variance = energy - mean_sq;  // never negative after truncation

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			block_valid  <= 1'b0;
			frame_last_q <= 1'b0;
			noise_valid  <= 1'b0;
			mean_sum     <= '0;
			var_sum      <= '0;
		end else begin
			block_valid <= stats_en;
			noise_valid <= block_valid && frame_last_q;
			if (stats_en) begin
				frame_last_q <= mean_res.frame_last;
				mean_sum     <= mean_sum + FSUM_WIDTH'(mean_res.mean);
				var_sum      <= var_sum + FSUM_WIDTH'(variance);
			end else if (block_valid && frame_last_q) begin
				// frame result is taken below and the next frame starts clean
				frame_last_q <= 1'b0;
				mean_sum     <= '0;
				var_sum      <= '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (stats_en) begin
			block_stats.mean     <= mean_res.mean;
			block_stats.variance <= variance;
		end
		if (block_valid && frame_last_q) begin
			noise.noise_mean     <= stat_t'(mean_sum >> log2_blocks);
			noise.noise_variance <= stat_t'(var_sum >> log2_blocks);
		end
	end

endmodule

// File: rtl/block_energy_unit.sv
//************************************************
// block energy unit
// squares accepted samples, sums the squares over
// one block and registers the truncated mean of
// squares
//************************************************

module block_energy_unit
	import noise_pkg::*;
#(
	parameter int LOG2_SAMPLES = 6
) (
	input  logic         clk,
	input  logic         rst_n,
	input  sample_beat_t beat,
	input  logic         beat_en,
	output logic         energy_ready,
	output stat_t        energy
);

	localparam int SUM_WIDTH = SQ_WIDTH + LOG2_SAMPLES;

	stat_t                sample_sq;
	logic [SUM_WIDTH-1:0] sum;
	logic [SUM_WIDTH-1:0] sum_next;

	assign sample_sq = SQ_WIDTH'(beat.data) * SQ_WIDTH'(beat.data);
	assign sum_next  = sum + SUM_WIDTH'(sample_sq);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sum          <= '0;
			energy_ready <= 1'b0;
		end else begin
			energy_ready <= beat_en && beat.block_last;  // in step with mean_ready
			if (beat_en) begin
				// restart at zero for the next block
				sum <= beat.block_last ? '0 : sum_next;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (beat_en && beat.block_last) begin
			energy <= stat_t'(sum_next >> LOG2_SAMPLES);
		end
	end

endmodule

// File: rtl/block_mean_unit.sv
//************************************************
// block mean unit
// sums accepted samples over one block and
// registers the truncated block mean
//************************************************

module block_mean_unit
	import noise_pkg::*;
#(
	parameter int LOG2_SAMPLES = 6
) (
	input  logic         clk,
	input  logic         rst_n,
	input  sample_beat_t beat,
	input  logic         beat_en,
	output logic         mean_ready,
	output mean_result_t mean_res
);

	localparam int SUM_WIDTH = DATA_WIDTH + LOG2_SAMPLES;

	logic [SUM_WIDTH-1:0] sum;
	logic [SUM_WIDTH-1:0] sum_next;

	// running sum including the current beat
	assign sum_next = sum + SUM_WIDTH'(beat.data);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sum        <= '0;
			mean_ready <= 1'b0;
		end else begin
			mean_ready <= beat_en && beat.block_last;
			if (beat_en) begin
				sum <= beat.block_last ? '0 : sum_next;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (beat_en && beat.block_last) begin
			mean_res.mean       <= stat_t'(sum_next >> LOG2_SAMPLES);
			mean_res.frame_last <= beat.frame_last;
		end
	end

endmodule

// File: rtl/noise_estimation_fsm.sv
//************************************************
// frame controller of the noise estimator
// idle / read_block / wait_stats FSM with sample
// and block counters, tags block and frame ends
// on the accepted beats
//************************************************

module noise_estimation_fsm
	import noise_pkg::*;
#(
	parameter int LOG2_SAMPLES = 6
) (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         start_of_frame,
	input  logic [2:0]   log2_blocks,
	input  sample_t      sample,
	input  logic         sample_valid,
	input  logic         block_valid,
	output logic         sampling,
	output sample_beat_t beat,
	output logic         beat_en
);

	typedef enum logic [1:0] {
		IDLE       = 2'd0,
		READ_BLOCK = 2'd1,
		WAIT_STATS = 2'd2
	} state_t;

	state_t state, next_state;

	logic [LOG2_SAMPLES-1:0]    sample_cnt;
	logic [MAX_LOG2_BLOCKS-1:0] block_cnt;
	logic [2:0]                 log2_blocks_q;  // frame size held for the whole frame
	logic [MAX_LOG2_BLOCKS:0]   num_blocks;
	logic                       block_end;
	logic                       last_block;

	assign num_blocks = (MAX_LOG2_BLOCKS + 1)'(1) << log2_blocks_q;
	assign last_block = ({1'b0, block_cnt} == num_blocks - 1'b1);

	assign sampling  = (state == READ_BLOCK);
	assign beat_en   = sampling && sample_valid;
	assign block_end = (sample_cnt == {LOG2_SAMPLES{1'b1}});

	// beat fields follow the counters and are qualified by beat_en
	assign beat.data       = sample;
	assign beat.block_last = block_end;
	assign beat.frame_last = block_end && last_block;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (start_of_frame) begin
					next_state = READ_BLOCK;
				end
			end
			READ_BLOCK: begin
				if (beat_en && block_end) begin
					next_state = WAIT_STATS;
				end
			end
			WAIT_STATS: begin
				// combiner has closed the block
				if (block_valid) begin
					next_state = last_block ? IDLE : READ_BLOCK;
				end
			end
			default: begin
				next_state = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sample_cnt    <= '0;
			block_cnt     <= '0;
			log2_blocks_q <= '0;
		end else begin
			case (state)
				IDLE: begin
					sample_cnt <= '0;
					block_cnt  <= '0;
					if (start_of_frame) begin
						log2_blocks_q <= log2_blocks;
					end
				end
				READ_BLOCK: begin
					if (beat_en) begin
						sample_cnt <= sample_cnt + 1'b1;  // wraps to 0 at block end
					end
				end
				WAIT_STATS: begin
					if (block_valid && !last_block) begin
						block_cnt <= block_cnt + 1'b1;
					end
				end
				default: begin
					sample_cnt <= '0;
					block_cnt  <= '0;
				end
			endcase
		end
	end

endmodule

// File: rtl/noise_pkg.sv
//************************************************
// shared definitions of the noise estimator
// sample and statistic widths, frame sizing and
// the packed structs passed between the blocks
//************************************************

package noise_pkg;

	localparam int DATA_WIDTH      = 8;
	localparam int MAX_LOG2_BLOCKS = 4;  // sizes the frame accumulators
	localparam int SQ_WIDTH        = 2 * DATA_WIDTH;

	typedef logic [DATA_WIDTH-1:0] sample_t;

	// mean, mean of squares or variance
	typedef logic [SQ_WIDTH-1:0] stat_t;

	// one accepted sample on its way to both units
	typedef struct packed {
		sample_t data;
		logic    block_last;
		logic    frame_last;
	} sample_beat_t;

	typedef struct packed {
		stat_t mean;
		logic  frame_last;  // block closes the frame
	} mean_result_t;

	typedef struct packed {
		stat_t mean;
		stat_t variance;
	} block_stats_t;

	typedef struct packed {
		stat_t noise_mean;
		stat_t noise_variance;
	} noise_result_t;

endpackage
